// ==== include/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// data path width in bits
`define WORD_SIZE 32

// architectural registers with r0 reading as zero
`define REG_COUNT 16

// low operand bits that form the shift amount
`define SHAMT_BITS 5

`endif

// ==== verilog/alu_pkg.sv ====
`include "alu_macros.svh"

package alu_pkg;

	// one data word of the integer path
	typedef logic [`WORD_SIZE-1:0] word_t;

	// alu operation codes
	// 0..7 fit a 3-bit control map
	// 8 and 9 extend it with the two compares
	typedef enum logic [3:0] {
		// arithmetic
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		// bitwise logic
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		// shifts by the low operand bits
		ALU_SL   = 4'd5,
		ALU_SRL  = 4'd6,
		// sign fill from bit 31
		ALU_SRA  = 4'd7,
		// set-less-than gives 1 or 0
		ALU_SLT  = 4'd8,
		// same compare with both operands unsigned
		ALU_SLTU = 4'd9
	} alu_op_e;

endpackage

// ==== verilog/exec_pkg.sv ====
`include "alu_macros.svh"

package exec_pkg;

	import alu_pkg::word_t;

	// register index, wide enough for REG_COUNT entries
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	// command held in the issue stage
	typedef struct packed {
		alu_pkg::alu_op_e op;
		// source registers
		reg_idx_t         rs1;
		reg_idx_t         rs2;
		// destination register
		reg_idx_t         rd;
		// second operand from imm instead of rs2
		logic             use_imm;
		word_t            imm;
	} issue_t;

	// write-back result on its way out
	typedef struct packed {
		reg_idx_t rd;
		word_t    data;
	} result_t;

endpackage

// ==== verilog/pipe_stage.sv ====
module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// free when empty or when the held item leaves this edge
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	// occupancy flag
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			// refill or drain in the same cycle
			out_valid <= in_valid;
		end
	end

	// payload register
	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

	// held item must not change until taken
	a_hold_stable: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data))
	);

endmodule

// ==== verilog/regfile.sv ====
`include "alu_macros.svh"

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  exec_pkg::reg_idx_t rd_idx_a,
	input  exec_pkg::reg_idx_t rd_idx_b,
	output alu_pkg::word_t     rd_data_a,
	output alu_pkg::word_t     rd_data_b,
	input  logic               wr_en,
	input  exec_pkg::reg_idx_t wr_idx,
	input  alu_pkg::word_t     wr_data
);

	import alu_pkg::*;

	word_t regs [`REG_COUNT];

	// write port that never writes r0
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// read ports are combinational
	// write lands on the edge, so the next cycle sees the new value
	always_comb begin
		if (rd_idx_a == '0) begin
			rd_data_a = '0;
		end else begin
			rd_data_a = regs[rd_idx_a];
		end
		if (rd_idx_b == '0) begin
			rd_data_b = '0;
		end else begin
			rd_data_b = regs[rd_idx_b];
		end
	end

	// index range against the architectural count
	a_wr_idx_range: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> (int'(wr_idx) < `REG_COUNT)
	);

endmodule

// ==== verilog/alu.sv ====
`include "alu_macros.svh"

module alu (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  alu_pkg::alu_op_e   op,
	input  alu_pkg::word_t     rs1_data,
	input  alu_pkg::word_t     rs2_data,
	input  alu_pkg::word_t     imm,
	input  logic               use_imm,
	input  exec_pkg::reg_idx_t rd,
	output logic               wr_en,
	output exec_pkg::reg_idx_t wr_idx,
	output alu_pkg::word_t     wr_data,
	output logic               out_valid,
	input  logic               out_ready,
	output exec_pkg::result_t  out_data
);

	import alu_pkg::*;

	word_t                  opnd_a;
	word_t                  opnd_b;
	logic [`SHAMT_BITS-1:0] shamt;
	word_t                  result;
	logic                   load;

	// second operand from register or immediate
	assign opnd_a = rs1_data;
	assign opnd_b = use_imm ? imm : rs2_data;
	// only the low bits count, so 33 shifts by 1
	assign shamt = opnd_b[`SHAMT_BITS-1:0];

	always_comb begin
		case (op)
			ALU_ADD:  result = opnd_a + opnd_b;
			ALU_SUB:  result = opnd_a - opnd_b;
			ALU_AND:  result = opnd_a & opnd_b;
			ALU_OR:   result = opnd_a | opnd_b;
			ALU_XOR:  result = opnd_a ^ opnd_b;
			ALU_SL:   result = opnd_a << shamt;
			ALU_SRL:  result = opnd_a >> shamt;
			// signed operand gives sign fill
			ALU_SRA:  result = $signed(opnd_a) >>> shamt;
			ALU_SLT:  result = word_t'($signed(opnd_a) < $signed(opnd_b));
			ALU_SLTU: result = word_t'(opnd_a < opnd_b);
			default:  result = '0;
		endcase
	end

	// result slot free when empty or drained this edge
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	// write-back on the same edge the result register loads
	// so a command issued right behind reads the new value
	assign wr_en = load;
	assign wr_idx = rd;
	assign wr_data = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// destination travels with the result data
	always_ff @(posedge clk) begin
		if (load) begin
			out_data.rd   <= rd;
			out_data.data <= result;
		end
	end

	// only the ten defined codes reach the alu
	a_op_legal: assert property (
		@(posedge clk) disable iff (reset)
		in_valid |-> (op inside {[ALU_ADD:ALU_SLTU]})
	);

	// no write-back while the result stage holds us off
	a_no_wr_stalled: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |-> !wr_en
	);

endmodule

// ==== verilog/exec_unit.sv ====
module exec_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  alu_pkg::alu_op_e   cmd_op,
	input  exec_pkg::reg_idx_t cmd_rs1,
	input  exec_pkg::reg_idx_t cmd_rs2,
	input  exec_pkg::reg_idx_t cmd_rd,
	input  logic               cmd_use_imm,
	input  alu_pkg::word_t     cmd_imm,
	output logic               res_valid,
	input  logic               res_ready,
	output exec_pkg::reg_idx_t res_rd,
	output alu_pkg::word_t     res_data
);

	import alu_pkg::*;
	import exec_pkg::*;

	issue_t  cmd_issue;
	issue_t  iss;
	logic    iss_valid;
	logic    iss_ready;
	word_t   rs1_data;
	word_t   rs2_data;
	logic    wr_en;
	reg_idx_t wr_idx;
	word_t   wr_data;
	logic    alu_valid;
	logic    alu_ready;
	result_t alu_res;
	result_t res;

	// command fields into one issue word
	assign cmd_issue.op      = cmd_op;
	assign cmd_issue.rs1     = cmd_rs1;
	assign cmd_issue.rs2     = cmd_rs2;
	assign cmd_issue.rd      = cmd_rd;
	assign cmd_issue.use_imm = cmd_use_imm;
	assign cmd_issue.imm     = cmd_imm;

	// stage 1 holds the command
	pipe_stage #(.payload_t(issue_t)) u_issue (
		.clk(clk), .reset(reset),
		.in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_issue),
		.out_valid(iss_valid), .out_ready(iss_ready), .out_data(iss)
	);

	// operands read straight from the issue stage indices
	regfile u_regfile (
		.clk(clk), .reset(reset),
		.rd_idx_a(iss.rs1), .rd_idx_b(iss.rs2),
		.rd_data_a(rs1_data), .rd_data_b(rs2_data),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	// stage 2 registers the alu result and drives write-back
	alu u_alu (
		.clk(clk), .reset(reset),
		.in_valid(iss_valid), .in_ready(iss_ready),
		.op(iss.op), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.imm(iss.imm), .use_imm(iss.use_imm), .rd(iss.rd),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.out_valid(alu_valid), .out_ready(alu_ready), .out_data(alu_res)
	);

	// stage 3 is the result register toward the port
	pipe_stage #(.payload_t(result_t)) u_result (
		.clk(clk), .reset(reset),
		.in_valid(alu_valid), .in_ready(alu_ready), .in_data(alu_res),
		.out_valid(res_valid), .out_ready(res_ready), .out_data(res)
	);

	assign res_rd   = res.rd;
	assign res_data = res.data;

endmodule

// ==== sim/exec_unit_tb.sv ====
module exec_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import alu_pkg::*;
	import exec_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_TESTS = 64;
	// words per line of the tests file
	localparam int FIELDS = 7;
	// valid after edge N+2, taken on edge N+3 with res_ready high
	localparam int ACCEPT_TO_TAKE = 3;

	logic     clk = 1'b0;
	logic     reset;
	logic     cmd_valid;
	logic     cmd_ready;
	alu_op_e  cmd_op;
	reg_idx_t cmd_rs1;
	reg_idx_t cmd_rs2;
	reg_idx_t cmd_rd;
	logic     cmd_use_imm;
	word_t    cmd_imm;
	logic     res_valid;
	logic     res_ready;
	reg_idx_t res_rd;
	word_t    res_data;

	logic [31:0] test_mem [FIELDS*MAX_TESTS];
	int          n_tests = 0;
	int          n_fixed = 0;
	int          results_seen = 0;
	int          errors = 0;
	int          cyc = 0;
	logic        stall_mode;
	integer      seed = 32'h97e4;
	logic [31:0] rnd;
	// accept edge and ready mode of each command in flight
	int          accept_q[$];
	logic        fixed_q[$];
	int          acc_cyc;
	logic        acc_fixed;
	int          rec;

	exec_unit u_dut (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
		.cmd_rs1(cmd_rs1), .cmd_rs2(cmd_rs2), .cmd_rd(cmd_rd),
		.cmd_use_imm(cmd_use_imm), .cmd_imm(cmd_imm),
		.res_valid(res_valid), .res_ready(res_ready),
		.res_rd(res_rd), .res_data(res_data)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// edge counter that reads as the value before each edge
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic report_mismatch(input string what, input int idx,
			input word_t got, input word_t exp);
		errors++;
		$display("FAILED at %0d ns: test %0d %s is %h, expected %h",
			$time, idx, what, got, exp);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR at %0d ns: %s", $time, msg);
	endtask

	task automatic print_summary();
		$display("errors: %0d, results checked: %0d of %0d", errors, results_seen, n_tests);
	endtask

	// put one file line on the command port
	task automatic drive_command(input int idx);
		int b;
		b = FIELDS * idx;
		cmd_op      <= alu_op_e'(test_mem[b][3:0]);
		cmd_rs1     <= test_mem[b+1][3:0];
		cmd_rs2     <= test_mem[b+2][3:0];
		cmd_rd      <= test_mem[b+3][3:0];
		cmd_use_imm <= test_mem[b+4][0];
		cmd_imm     <= test_mem[b+5];
		cmd_valid   <= 1'b1;
	endtask

	// sink is always ready first and random later
	initial begin
		res_ready <= 1'b1;
		forever begin
			@(posedge clk);
			if (stall_mode) begin
				rnd = $random(seed);
				res_ready <= rnd[0];
			end
		end
	end

	// in-order checker on both handshakes
	always @(posedge clk) begin
		if (!reset) begin
			if (cmd_valid && cmd_ready) begin
				accept_q.push_back(cyc);
				fixed_q.push_back(!stall_mode);
			end
			if (res_valid && res_ready) begin
				rec = results_seen;
				assert (rec < n_tests && accept_q.size() > 0) else
					report_problem("a result came out with no command left to match it");
				if (rec < n_tests && accept_q.size() > 0) begin
					acc_cyc = accept_q.pop_front();
					acc_fixed = fixed_q.pop_front();
					assert (res_rd === test_mem[FIELDS*rec+3][3:0]) else
						report_mismatch("rd", rec, word_t'(res_rd), test_mem[FIELDS*rec+3]);
					assert (res_data === test_mem[FIELDS*rec+6]) else
						report_mismatch("data", rec, res_data, test_mem[FIELDS*rec+6]);
					// latency only counts with no back-pressure
					if (acc_fixed) begin
						assert (cyc - acc_cyc == ACCEPT_TO_TAKE) else
							report_mismatch("edges from accept to take", rec,
								word_t'(cyc - acc_cyc), ACCEPT_TO_TAKE);
					end
				end
				results_seen <= results_seen + 1;
			end
		end
	end

	initial begin
		reset       <= 1'b1;
		cmd_valid   <= 1'b0;
		cmd_op      <= ALU_ADD;
		cmd_rs1     <= '0;
		cmd_rs2     <= '0;
		cmd_rd      <= '0;
		cmd_use_imm <= 1'b0;
		cmd_imm     <= '0;
		stall_mode  <= 1'b0;
		$readmemh("sim/exec_tests.txt", test_mem);
		while (n_tests < MAX_TESTS && !$isunknown(test_mem[FIELDS*n_tests])) begin
			n_tests++;
		end
		// res_ready stays high for the first half and is random for the rest
		n_fixed = n_tests / 2;
		if (n_tests == 0) begin
			report_problem("no tests were read from sim/exec_tests.txt");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		assert (cmd_ready === 1'b1 && res_valid === 1'b0 && u_dut.wr_en === 1'b0) else
			report_problem("the unit is not idle after reset");
		for (int i = 0; i < n_tests; i++) begin
			if (i == n_fixed && i > 0) begin
				// drain before stalls begin
				cmd_valid <= 1'b0;
				while (results_seen < n_fixed) @(posedge clk);
				stall_mode <= 1'b1;
			end
			drive_command(i);
			@(posedge clk);
			while (!cmd_ready) @(posedge clk);
		end
		cmd_valid <= 1'b0;
		while (results_seen < n_tests) @(posedge clk);
		// idle a few cycles to catch anything extra
		repeat (4) @(posedge clk);
		assert (results_seen == n_tests) else
			report_problem("more results came out than commands went in");
		print_summary();
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// 20 cycles per test plus reset
	initial begin
		wait (n_tests > 0);
		#((n_tests * 20 + RESET_CYCLES) * CLK_PERIOD);
		report_problem("timeout, results stopped arriving");
		print_summary();
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim/exec_tests.txt ====
// op rs1 rs2 rd use_imm imm expected, all hex
// op codes: 0 add 1 sub 2 and 3 or 4 xor 5 sl 6 srl 7 sra 8 slt 9 sltu
0 0 0 1 1 7fffffff 7fffffff
0 0 0 2 1 00000001 00000001
0 0 0 3 1 80000000 80000000
0 0 0 4 1 fffffff0 fffffff0
0 0 0 5 1 0f0f00ff 0f0f00ff
0 1 2 6 0 00000000 80000000
0 4 5 7 0 00000000 0f0f00ef
1 2 3 8 0 00000000 80000001
1 0 2 9 0 00000000 ffffffff
2 5 4 a 0 00000000 0f0f00f0
3 5 3 b 0 00000000 8f0f00ff
4 5 9 c 0 00000000 f0f0ff00
5 5 0 d 1 00000000 0f0f00ff
5 2 0 d 1 0000001f 80000000
6 d 0 e 1 00000001 40000000
7 d 0 e 1 00000001 c0000000
7 d 0 f 1 0000001f ffffffff
7 1 0 f 1 0000001f 00000000
6 d 0 f 1 0000001f 00000001
6 4 0 f 1 00000021 7ffffff8
7 4 0 f 1 00000021 fffffff8
5 5 0 f 1 00000021 1e1e01fe
8 4 2 a 0 00000000 00000001
9 4 2 b 0 00000000 00000000
8 5 5 c 0 00000000 00000000
9 5 5 c 0 00000000 00000000
0 0 0 0 1 12345678 12345678
0 0 0 a 0 00000000 00000000
9 2 4 b 0 00000000 00000001
0 b 2 d 0 00000000 00000002
8 2 4 c 0 00000000 00000000

// ==== list.f ====
+incdir+include
verilog/alu_pkg.sv
verilog/exec_pkg.sv
verilog/pipe_stage.sv
verilog/regfile.sv
verilog/alu.sv
verilog/exec_unit.sv
sim/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/alu_pkg.sv
      - verilog/exec_pkg.sv
      - verilog/pipe_stage.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/exec_unit.sv

  - target: simulation
    files:
      - sim/exec_unit_tb.sv
